// ==== usbfs_defs.svh ====
`ifndef USBFS_DEFS_SVH
`define USBFS_DEFS_SVH

// Largest data payload in one packet, a power of two.
`define USBFS_MAX_PKT 8

// Upload FIFO entries.
`define USBFS_FIFO_DEPTH 16

// 4-bit PID codes that the check nibble is formed from.
`define USBFS_PID_DATA0 4'h3
`define USBFS_PID_DATA1 4'hB
`define USBFS_PID_NAK   4'hA

`endif

// ==== usbfs_pkg.sv ====
package usbfs_pkg;

  // PID byte on the wire. Check nibble is the complement of the code.
  typedef struct packed {
    logic [3:0] chk;
    logic [3:0] code;
  } usbfs_pid_s;

  typedef union packed {
    logic [7:0] raw;   // Byte as sent.
    usbfs_pid_s f;     // Field view.
  } usbfs_pid_u;

  // Transactor states.
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PID,
    ST_FILL,     // Waiting for the buffer fill to end.
    ST_DATA,
    ST_CRC_LO,
    ST_CRC_HI,
    ST_ACK       // Packet sent, awaiting host handshake.
  } usbfs_tx_state_e;

endpackage

// ==== usbfs_et_if.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

interface usbfs_et_if;
  localparam int IDX_W = $clog2(`USBFS_MAX_PKT);

  logic             et_valid;     // Endpoint has data waiting.
  logic             et_ready;     // Host ACK taken.
  logic             tx_accepted;  // Fresh data PID has moved.
  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  logic [7:0]       wr_byte;
  logic             wr_done;      // Fill finished.

  modport endp (output et_valid, wr_en, wr_idx, wr_byte, wr_done,
                input  tx_accepted);

  modport txr (output et_ready, tx_accepted,
               input  et_valid, wr_done);

  // Packet buffer side.
  modport pbuf (input wr_en, wr_idx, wr_byte, wr_done, et_ready);

endinterface

// ==== usbfs_fifo.sv ====
`timescale 1ns/1ps

module usbfs_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = i_push && !o_full;   // Push into a full FIFO is dropped.
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge i_clk) begin
    if (do_push) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry.
  assign o_data  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));

endmodule

// ==== usbfs_endp_tx.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

module usbfs_endp_tx (
  input  logic       i_clk,
  input  logic       i_rst_n,

  input  logic       i_fifo_empty,
  input  logic [7:0] i_fifo_byte,
  output logic       o_fifo_pop,

  usbfs_et_if.endp   et
);

  localparam int IDX_W = $clog2(`USBFS_MAX_PKT);

  logic             writing_q;  // Fill in progress.
  logic             last_q;     // Final buffer slot has been written.
  logic [IDX_W-1:0] idx_q;
  logic             fill_end;

  // Fill ends when the FIFO runs dry or the packet is full.
  assign fill_end = writing_q && (i_fifo_empty || last_q);

  assign et.wr_en    = writing_q && !i_fifo_empty && !last_q;
  assign et.wr_byte  = i_fifo_byte;   // Head byte leaves with the pop.
  assign et.wr_idx   = idx_q;
  assign et.wr_done  = fill_end;
  assign et.et_valid = !i_fifo_empty;

  assign o_fifo_pop = et.wr_en;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      writing_q <= 1'b0;
      last_q    <= 1'b0;
      idx_q     <= '0;
    end else begin
      if (et.tx_accepted)
        writing_q <= 1'b1;
      else if (fill_end)
        writing_q <= 1'b0;

      // Index restarts at the end of every packet.
      if (fill_end) begin
        idx_q  <= '0;
        last_q <= 1'b0;
      end else if (et.wr_en) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == IDX_W'(`USBFS_MAX_PKT - 1)) last_q <= 1'b1;
      end
    end
  end

endmodule

// ==== usbfs_pkt_buf.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

module usbfs_pkt_buf (
  input  logic                                i_clk,
  input  logic                                i_rst_n,

  usbfs_et_if.pbuf                            et,

  input  logic [$clog2(`USBFS_MAX_PKT)-1:0]   i_rd_idx,
  output logic [7:0]                          o_rd_byte,
  output logic [$clog2(`USBFS_MAX_PKT):0]     o_len
);

  localparam int IDX_W = $clog2(`USBFS_MAX_PKT);

  logic [7:0]   mem [`USBFS_MAX_PKT];
  logic [IDX_W:0] cnt_q;   // Writes seen in the current fill.
  logic [IDX_W:0] len_q;

  always_ff @(posedge i_clk) begin
    if (et.wr_en) mem[et.wr_idx] <= et.wr_byte;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
      len_q <= '0;
    end else if (et.wr_done) begin
      len_q <= cnt_q;   // Length for sending and any retry.
      cnt_q <= '0;
    end else begin
      if (et.wr_en) cnt_q <= cnt_q + 1'b1;
      // Acknowledged packet is released.
      if (et.et_ready) len_q <= '0;
    end
  end

  assign o_rd_byte = mem[i_rd_idx];
  assign o_len     = len_q;

endmodule

// ==== usbfs_crc16.sv ====
`timescale 1ns/1ps

module usbfs_crc16 (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_clear,
  input  logic        i_en,
  input  logic [7:0]  i_byte,
  output logic [15:0] o_crc
);

  logic [15:0] crc_q;

  // One byte through the reflected 0xA001 polynomial, LSB first.
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ b[i])
        c = (c >> 1) ^ 16'hA001;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear)
      crc_q <= 16'hFFFF;   // Preset.
    else if (i_en)
      crc_q <= crc_step(crc_q, i_byte);
  end

  assign o_crc = ~crc_q;   // Sent low byte first.

endmodule

// ==== usbfs_tx_packer.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

module usbfs_tx_packer (
  input  logic                                i_clk,
  input  logic                                i_rst_n,

  input  logic                                i_in_token,
  input  logic                                i_ack,

  usbfs_et_if.txr                             et,

  output logic [$clog2(`USBFS_MAX_PKT)-1:0]   o_rd_idx,
  input  logic [7:0]                          i_rd_byte,
  input  logic [$clog2(`USBFS_MAX_PKT):0]     i_len,

  output logic                                o_crc_clear,
  output logic                                o_crc_en,
  input  logic [15:0]                         i_crc,

  output logic                                o_tx_valid,
  output logic [7:0]                          o_tx_byte,
  output logic                                o_tx_last,
  input  logic                                i_tx_ready
);

  import usbfs_pkg::*;

  localparam int IDX_W = $clog2(`USBFS_MAX_PKT);

  usbfs_tx_state_e  state_q;
  logic             toggle_q;   // Low for DATA0.
  logic             pending_q;  // Sent packet not yet acknowledged.
  logic             nak_q;
  logic             fresh_q;    // Current packet needs a fill.
  logic [IDX_W-1:0] rd_idx_q;
  logic             xfer;
  logic             ack_take;
  logic             start;
  logic             last_data;
  usbfs_pid_u       pid;

  assign xfer      = o_tx_valid && i_tx_ready;
  assign ack_take  = i_ack && (state_q == ST_ACK);
  assign start     = i_in_token && !ack_take && (state_q == ST_IDLE || state_q == ST_ACK);
  assign last_data = (({1'b0, rd_idx_q} + 1'b1) == i_len);

  always_comb begin
    if (nak_q)
      pid.f.code = `USBFS_PID_NAK;
    else
      pid.f.code = toggle_q ? `USBFS_PID_DATA1 : `USBFS_PID_DATA0;
    pid.f.chk = ~pid.f.code;
  end

  // Outputs decode from registered state, so they hold until taken.
  always_comb begin
    o_tx_valid = 1'b0;
    o_tx_byte  = pid.raw;
    o_tx_last  = 1'b0;
    case (state_q)
      ST_PID: begin
        o_tx_valid = 1'b1;
        o_tx_last  = nak_q;   // NAK is a lone byte.
      end
      ST_DATA: begin
        o_tx_valid = 1'b1;
        o_tx_byte  = i_rd_byte;
      end
      ST_CRC_LO: begin
        o_tx_valid = 1'b1;
        o_tx_byte  = i_crc[7:0];
      end
      ST_CRC_HI: begin
        o_tx_valid = 1'b1;
        o_tx_byte  = i_crc[15:8];
        o_tx_last  = 1'b1;
      end
      default: o_tx_valid = 1'b0;
    endcase
  end

  assign o_rd_idx       = rd_idx_q;
  assign o_crc_clear    = start;
  assign o_crc_en       = (state_q == ST_DATA) && xfer;
  assign et.tx_accepted = (state_q == ST_PID) && fresh_q && xfer;
  assign et.et_ready    = ack_take;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q   <= ST_IDLE;
      toggle_q  <= 1'b0;
      pending_q <= 1'b0;
      nak_q     <= 1'b0;
      fresh_q   <= 1'b0;
      rd_idx_q  <= '0;
    end else begin
      if (ack_take) begin
        toggle_q  <= !toggle_q;
        pending_q <= 1'b0;
        state_q   <= ST_IDLE;
      end else if (start) begin
        // Retry first, then new data, else NAK.
        state_q  <= ST_PID;
        rd_idx_q <= '0;
        nak_q    <= !pending_q && !et.et_valid;
        fresh_q  <= !pending_q && et.et_valid;
      end else begin
        case (state_q)
          ST_PID: if (xfer) state_q <= nak_q ? ST_IDLE : (fresh_q ? ST_FILL : ST_DATA);
          ST_FILL: if (et.wr_done) state_q <= ST_DATA;
          ST_DATA: begin
            if (xfer) begin
              if (last_data) state_q <= ST_CRC_LO;
              else rd_idx_q <= rd_idx_q + 1'b1;
            end
          end
          ST_CRC_LO: if (xfer) state_q <= ST_CRC_HI;
          ST_CRC_HI: begin
            if (xfer) begin
              state_q   <= ST_ACK;
              pending_q <= 1'b1;
            end
          end
          default: state_q <= state_q;
        endcase
      end
    end
  end

endmodule

// ==== usbfs_in_top.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

module usbfs_in_top (
  input  logic       i_clk,
  input  logic       i_rst_n,

  input  logic       i_valid,
  input  logic [7:0] i_data,
  output logic       o_ready,

  input  logic       i_in_token,
  input  logic       i_ack,

  output logic       o_tx_valid,
  output logic [7:0] o_tx_byte,
  output logic       o_tx_last,
  input  logic       i_tx_ready
);

  localparam int IDX_W = $clog2(`USBFS_MAX_PKT);

  logic             fifo_empty;
  logic             fifo_full;
  logic             fifo_pop;
  logic [7:0]       fifo_byte;
  logic [IDX_W-1:0] rd_idx;
  logic [7:0]       rd_byte;
  logic [IDX_W:0]   len;
  logic             crc_clear;
  logic             crc_en;
  logic [15:0]      crc;

  usbfs_et_if et_if ();

  usbfs_fifo #(
    .WIDTH (8),
    .DEPTH (`USBFS_FIFO_DEPTH)
  ) u_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (i_valid && o_ready),
    .i_data  (i_data),
    .i_pop   (fifo_pop),
    .o_data  (fifo_byte),
    .o_empty (fifo_empty),
    .o_full  (fifo_full)
  );

  assign o_ready = !fifo_full;

  usbfs_endp_tx u_endp_tx (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fifo_empty (fifo_empty),
    .i_fifo_byte  (fifo_byte),
    .o_fifo_pop   (fifo_pop),
    .et           (et_if)
  );

  usbfs_pkt_buf u_pkt_buf (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .et        (et_if),
    .i_rd_idx  (rd_idx),
    .o_rd_byte (rd_byte),
    .o_len     (len)
  );

  // Fed with each data byte as it moves to the PHY.
  usbfs_crc16 u_crc16 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_clear (crc_clear),
    .i_en    (crc_en),
    .i_byte  (rd_byte),
    .o_crc   (crc)
  );

  usbfs_tx_packer u_tx_packer (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_in_token  (i_in_token),
    .i_ack       (i_ack),
    .et          (et_if),
    .o_rd_idx    (rd_idx),
    .i_rd_byte   (rd_byte),
    .i_len       (len),
    .o_crc_clear (crc_clear),
    .o_crc_en    (crc_en),
    .i_crc       (crc),
    .o_tx_valid  (o_tx_valid),
    .o_tx_byte   (o_tx_byte),
    .o_tx_last   (o_tx_last),
    .i_tx_ready  (i_tx_ready)
  );

endmodule

// ==== tb_usbfs_in.sv ====
`timescale 1ns/1ps
`include "usbfs_defs.svh"

module tb_usbfs_in;

  import usbfs_pkg::*;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_valid;
  logic [7:0] i_data;
  logic       o_ready;
  logic       i_in_token;
  logic       i_ack;
  logic       o_tx_valid;
  logic [7:0] o_tx_byte;
  logic       o_tx_last;
  logic       i_tx_ready;

  logic [7:0] rx_bytes [$];   // Bytes taken on the PHY side.
  logic       rx_last [$];
  logic       data_toggle = 1'b0;   // Expected data PID, low for DATA0.
  int         fd;
  int         limit = 200;    // Raised by 200 cycles for every command read.
  int         cycles = 0;
  int         checks = 0;
  int         errs = 0;
  int         test_errs = 0;
  int         tests = 0;
  int         failed_tests = 0;

  usbfs_in_top UUT (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_data     (i_data),
    .o_ready    (o_ready),
    .i_in_token (i_in_token),
    .i_ack      (i_ack),
    .o_tx_valid (o_tx_valid),
    .o_tx_byte  (o_tx_byte),
    .o_tx_last  (o_tx_last),
    .i_tx_ready (i_tx_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // PHY model. A byte is logged when it moves on the coming rising edge.
  initial begin
    i_tx_ready = 1'b0;
    forever begin
      @(negedge i_clk);
      i_tx_ready = (($urandom % 4) != 0);   // Low about one cycle in four.
      if (o_tx_valid && i_tx_ready) begin
        rx_bytes.push_back(o_tx_byte);
        rx_last.push_back(o_tx_last);
      end
    end
  end

  initial begin
    while (cycles <= limit) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles waiting on the DUT", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      errs++;
      test_errs++;
    end
  endtask

  // Pushes bytes with random idle gaps, honoring o_ready.
  task automatic upload_bytes();
    int         n;
    logic [7:0] b;
    void'($fscanf(fd, "%d", n));
    for (int i = 0; i < n; i++) begin
      void'($fscanf(fd, "%h", b));
      repeat ($urandom % 3) @(negedge i_clk);
      i_valid = 1'b1;
      i_data  = b;
      while (!o_ready) @(negedge i_clk);
      @(negedge i_clk);
      i_valid = 1'b0;
    end
  endtask

  task automatic send_pulse(input logic ack);
    if (ack)
      i_ack = 1'b1;
    else
      i_in_token = 1'b1;
    @(negedge i_clk);
    i_ack      = 1'b0;
    i_in_token = 1'b0;
  endtask

  task automatic expect_packet();
    int         n;
    logic [7:0] exp_b;
    logic [7:0] got;
    logic       last;
    usbfs_pid_u pid;
    void'($fscanf(fd, "%d", n));
    for (int i = 0; i < n; i++) begin
      void'($fscanf(fd, "%h", exp_b));
      while (rx_bytes.size() == 0) @(negedge i_clk);
      got  = rx_bytes.pop_front();
      last = rx_last.pop_front();
      compare_byte(got, exp_b, $sformatf("byte %0d", i));
      compare_byte({7'd0, last}, {7'd0, i == n - 1}, $sformatf("last flag of byte %0d", i));
      if (i == 0) begin
        // A lone byte is a NAK.
        if (n == 1)
          pid.f.code = `USBFS_PID_NAK;
        else
          pid.f.code = data_toggle ? `USBFS_PID_DATA1 : `USBFS_PID_DATA0;
        pid.f.chk = ~pid.f.code;
        compare_byte(got, pid.raw, "PID byte");
      end
    end
    @(negedge i_clk);   // The final byte has moved by now.
  endtask

  task automatic end_test();
    string name;
    void'($fscanf(fd, "%s", name));
    tests++;
    if (test_errs != 0) failed_tests++;
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    test_errs = 0;
  endtask

  task automatic run_commands();
    string cmd;
    string line;
    while (!$feof(fd)) begin
      if ($fscanf(fd, "%s", cmd) == 1) begin
        limit += 200;
        if (cmd == "#")
          void'($fgets(line, fd));   // Rest of a comment line.
        else if (cmd == "L")
          upload_bytes();
        else if (cmd == "I")
          send_pulse(1'b0);
        else if (cmd == "A") begin
          send_pulse(1'b1);
          data_toggle = !data_toggle;   // Each ACK flips DATA0 and DATA1.
        end
        else if (cmd == "E")
          expect_packet();
        else if (cmd == "T")
          end_test();
        else begin
          $display("Unknown command %s in the data file", cmd);
          errs++;
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'h51a7));
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    i_data     = 8'h00;
    i_in_token = 1'b0;
    i_ack      = 1'b0;
    fd = $fopen("usbfs_in_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file usbfs_in_input.txt");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      repeat (8) @(negedge i_clk);
      compare_byte({7'd0, o_ready}, 8'd1, "o_ready in reset");
      compare_byte({7'd0, o_tx_valid}, 8'd0, "o_tx_valid in reset");
      compare_byte({7'd0, o_tx_last}, 8'd0, "o_tx_last in reset");
      i_rst_n = 1'b1;
      run_commands();
      $fclose(fd);
      compare_byte(8'(rx_bytes.size()), 8'd0, "count of unexpected bytes");
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errs);
      if (errs == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// ==== usbfs_in_input.txt ====
# Commands: L count bytes (upload), I (IN token), A (ACK), T name (end of test),
# E count bytes (one packet on the PHY side: PID, data, CRC low, CRC high). Bytes in hex.
L 5 12 34 56 78 9A
I
E 8 C3 12 34 56 78 9A 2F B7
T fresh_packet
I
E 8 C3 12 34 56 78 9A 2F B7
A
L 3 0F 1E 2D
I
E 6 4B 0F 1E 2D 77 81
A
T retry
L 11 12 34 56 78 9A BC DE F0 0F 1E 2D
I
E 11 C3 12 34 56 78 9A BC DE F0 50 06
A
I
E 6 4B 0F 1E 2D 77 81
A
T size_limit
I
E 1 5A
T nak
L 4 12 34 56 78
I
E 7 C3 12 34 56 78 84 EF
I
L 3 0F 1E 2D
E 7 C3 12 34 56 78 84 EF
A
I
E 6 4B 0F 1E 2D 77 81
A
T back_pressure

// ==== filelist.f ====
+incdir+.
usbfs_pkg.sv
usbfs_et_if.sv
usbfs_fifo.sv
usbfs_endp_tx.sv
usbfs_pkt_buf.sv
usbfs_crc16.sv
usbfs_tx_packer.sv
usbfs_in_top.sv
tb_usbfs_in.sv

// ==== Makefile ====
TOP := tb_usbfs_in

sim:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
